// ==== common/dcache_defines.svh ====
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// log2 of cache size in bytes
`define CACHE_SIZE_E 12
`define CBANKS 4
`define CASSOC 2
// 32-bit words per bank row
`define CWIDTH 2

// derived field widths
`define WORD_W ($clog2(`CWIDTH))
`define BANK_W ($clog2(`CBANKS))
`define WAY_W ($clog2(`CASSOC))
`define ROW_W (`CACHE_SIZE_E - 2 - `WAY_W - `BANK_W - `WORD_W)

// word index inside one way
`define IDX_W (`WORD_W + `BANK_W + `ROW_W)

// refill / write-back line address, way above row above bank
`define LINE_W (`WAY_W + `ROW_W + `BANK_W)

`endif

// ==== common/dcache_pkg.sv ====
`include "dcache_defines.svh"

package dcache_pkg;

    // one bank row holds every way side by side
    typedef logic [`CASSOC-1:0][`CWIDTH-1:0][31:0] bank_row_t;
    typedef logic [`CASSOC-1:0][`CWIDTH-1:0][3:0] bank_mask_t;

    typedef struct packed {
        logic ce_n;
        logic [`WAY_W-1:0] way;
        logic [`IDX_W-1:0] idx;
        logic [31:0] data;
        logic [3:0] wmask;
    } core_wr_t;

    typedef struct packed {
        logic ce_n;
        logic [`IDX_W-1:0] idx;
    } core_rd_t;

    // refill write or write-back read
    typedef struct packed {
        logic ce_n;
        logic [`LINE_W-1:0] line;
        logic [`CWIDTH-1:0][31:0] data;
        logic [`CWIDTH-1:0][3:0] wmask;
    } line_req_t;

    typedef struct packed {
        logic ce_n;
        logic [`ROW_W-1:0] row;
        bank_row_t data;
        bank_mask_t wmask;
    } bank_wr_t;

    typedef struct packed {
        logic ce_n;
        logic [`ROW_W-1:0] row;
    } bank_rd_t;

endpackage

// ==== dcache/dcache_sram.sv ====
`timescale 1ns/1ps

module dcache_sram #(
    parameter int WIDTH     = 128,
    parameter int DEPTH     = 64,
    parameter int MASK_GRAN = 8
) (
    input  logic                       clk,

    // port 0, masked write
    input  logic                       ce_n,
    input  logic                       we_n,
    input  logic [$clog2(DEPTH)-1:0]   addr,
    input  logic [WIDTH-1:0]           wdata,
    input  logic [WIDTH/MASK_GRAN-1:0] wmask,

    // port 1, read
    input  logic                       rce_n,
    input  logic [$clog2(DEPTH)-1:0]   raddr,
    output logic [WIDTH-1:0]           rdata
);

    localparam int ADDR_W = $clog2(DEPTH);
    localparam int LANES  = WIDTH / MASK_GRAN;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [ADDR_W-1:0] raddr_q;
    logic rd_pend;

    always_ff @(posedge clk) begin
        if (!ce_n && !we_n) begin
            for (int i = 0; i < LANES; i++) begin
                if (wmask[i])
                    mem[addr][i*MASK_GRAN +: MASK_GRAN] <= wdata[i*MASK_GRAN +: MASK_GRAN];
            end
        end
    end

    // address stage then data stage
    always_ff @(posedge clk) begin
        rd_pend <= !rce_n;
        if (!rce_n)
            raddr_q <= raddr;
        if (rd_pend)
            rdata <= mem[raddr_q];
    end

endmodule

// ==== dcache/dcache_wr_route.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_wr_route (
    input  dcache_pkg::core_wr_t  core_wr,
    input  dcache_pkg::line_req_t line_wr,
    output dcache_pkg::bank_wr_t  bank_wr [`CBANKS],
    output logic                  wbusy
);

    logic [`WORD_W-1:0] core_word;
    logic [`BANK_W-1:0] core_bank;
    logic [`ROW_W-1:0] core_row;
    logic [`WAY_W-1:0] line_way;
    logic [`BANK_W-1:0] line_bank;
    logic [`ROW_W-1:0] line_row;
    dcache_pkg::bank_wr_t core_req;
    dcache_pkg::bank_wr_t line_req;

    // core index packs row above bank above word
    assign core_word = core_wr.idx[`WORD_W-1:0];
    assign core_bank = core_wr.idx[`WORD_W +: `BANK_W];
    assign core_row  = core_wr.idx[`WORD_W+`BANK_W +: `ROW_W];

    assign line_bank = line_wr.line[`BANK_W-1:0];
    assign line_row  = line_wr.line[`BANK_W +: `ROW_W];
    assign line_way  = line_wr.line[`BANK_W+`ROW_W +: `WAY_W];

    // store word copied everywhere, mask picks way and word
    always_comb begin
        core_req = '0;
        core_req.row = core_row;
        core_req.data = {(`CASSOC*`CWIDTH){core_wr.data}};
        core_req.wmask[core_wr.way][core_word] = core_wr.wmask;
    end

    always_comb begin
        line_req = '0;
        line_req.row = line_row;
        line_req.data = {`CASSOC{line_wr.data}};
        line_req.wmask[line_way] = line_wr.wmask;
    end

    always_comb begin
        for (int b = 0; b < `CBANKS; b++) begin
            bank_wr[b] = '0;
            bank_wr[b].ce_n = 1'b1;
        end
        if (!core_wr.ce_n)
            bank_wr[core_bank] = core_req;
        // refill always wins its bank
        if (!line_wr.ce_n)
            bank_wr[line_bank] = line_req;
    end

    assign wbusy = !line_wr.ce_n && !core_wr.ce_n && (core_bank == line_bank);

endmodule

// ==== dcache/dcache_rd_route.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_rd_route (
    input  logic                     clk,
    input  logic                     rst_n,

    input  dcache_pkg::core_rd_t     core_rd,
    input  dcache_pkg::line_req_t    line_rd,

    output dcache_pkg::bank_rd_t     bank_rd [`CBANKS],
    input  dcache_pkg::bank_row_t    bank_data [`CBANKS],

    output logic [`CASSOC-1:0][31:0] core_rdata,
    output logic [`CWIDTH-1:0][31:0] line_rdata,
    output logic                     rbusy,
    output logic [`BANK_W-1:0]       rbusy_bank
);

    typedef struct packed {
        logic vld;
        logic [`BANK_W-1:0] bank;
        logic [`WORD_W-1:0] word;
    } core_tag_t;

    typedef struct packed {
        logic vld;
        logic [`WAY_W-1:0] way;
        logic [`BANK_W-1:0] bank;
    } line_tag_t;

    logic [`WORD_W-1:0] core_word;
    logic [`BANK_W-1:0] core_bank;
    logic [`ROW_W-1:0] core_row;
    logic [`WAY_W-1:0] line_way;
    logic [`BANK_W-1:0] line_bank;
    logic [`ROW_W-1:0] line_row;
    logic core_go;
    logic line_go;
    core_tag_t [1:0] core_tag;
    line_tag_t [1:0] line_tag;
    dcache_pkg::bank_row_t core_row_data;

    assign core_word = core_rd.idx[`WORD_W-1:0];
    assign core_bank = core_rd.idx[`WORD_W +: `BANK_W];
    assign core_row  = core_rd.idx[`WORD_W+`BANK_W +: `ROW_W];

    assign line_bank = line_rd.line[`BANK_W-1:0];
    assign line_row  = line_rd.line[`BANK_W +: `ROW_W];
    assign line_way  = line_rd.line[`BANK_W+`ROW_W +: `WAY_W];

    // core read is dropped when write-back takes its bank
    assign line_go = !line_rd.ce_n;
    assign core_go = !core_rd.ce_n && !(line_go && (line_bank == core_bank));

    always_comb begin
        for (int b = 0; b < `CBANKS; b++) begin
            bank_rd[b].ce_n = 1'b1;
            bank_rd[b].row = '0;
        end
        if (core_go) begin
            bank_rd[core_bank].ce_n = 1'b0;
            bank_rd[core_bank].row = core_row;
        end
        if (line_go) begin
            bank_rd[line_bank].ce_n = 1'b0;
            bank_rd[line_bank].row = line_row;
        end
    end

    assign rbusy = line_go;
    assign rbusy_bank = line_go ? line_bank : '0;

    // two stages to match sram read latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            core_tag <= '0;
            line_tag <= '0;
        end else begin
            core_tag[1] <= core_tag[0];
            core_tag[0] <= '{vld: core_go, bank: core_bank, word: core_word};
            line_tag[1] <= line_tag[0];
            line_tag[0] <= '{vld: line_go, way: line_way, bank: line_bank};
        end
    end

    // transpose to one word per way
    always_comb begin
        core_row_data = bank_data[core_tag[1].bank];
        for (int a = 0; a < `CASSOC; a++)
            core_rdata[a] = core_tag[1].vld ? core_row_data[a][core_tag[1].word] : '0;
    end

    assign line_rdata = line_tag[1].vld ? bank_data[line_tag[1].bank][line_tag[1].way] : '0;

endmodule

// ==== dcache/dcache_banks.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_banks (
    input  logic                     clk,
    input  logic                     rst_n,

    input  dcache_pkg::core_wr_t     core_wr,
    input  dcache_pkg::core_rd_t     core_rd,
    input  dcache_pkg::line_req_t    line_wr,
    input  dcache_pkg::line_req_t    line_rd,

    output logic [`CASSOC-1:0][31:0] core_rdata,
    output logic [`CWIDTH-1:0][31:0] line_rdata,
    output logic                     wbusy,
    output logic                     rbusy,
    output logic [`BANK_W-1:0]       rbusy_bank
);

    dcache_pkg::bank_wr_t bank_wr [`CBANKS];
    dcache_pkg::bank_rd_t bank_rd [`CBANKS];
    dcache_pkg::bank_row_t bank_data [`CBANKS];

    dcache_wr_route u_wr_route (
        .core_wr (core_wr),
        .line_wr (line_wr),
        .bank_wr (bank_wr),
        .wbusy   (wbusy)
    );

    dcache_rd_route u_rd_route (
        .clk        (clk),
        .rst_n      (rst_n),
        .core_rd    (core_rd),
        .line_rd    (line_rd),
        .bank_rd    (bank_rd),
        .bank_data  (bank_data),
        .core_rdata (core_rdata),
        .line_rdata (line_rdata),
        .rbusy      (rbusy),
        .rbusy_bank (rbusy_bank)
    );

    // one row holds all ways, byte write enables
    for (genvar i = 0; i < `CBANKS; i++) begin : g_bank
        dcache_sram #(
            .WIDTH     ($bits(dcache_pkg::bank_row_t)),
            .DEPTH     (1 << `ROW_W),
            .MASK_GRAN (8)
        ) u_sram (
            .clk   (clk),
            .ce_n  (bank_wr[i].ce_n),
            .we_n  (bank_wr[i].ce_n),
            .addr  (bank_wr[i].row),
            .wdata (bank_wr[i].data),
            .wmask (bank_wr[i].wmask),
            .rce_n (bank_rd[i].ce_n),
            .raddr (bank_rd[i].row),
            .rdata (bank_data[i])
        );
    end

endmodule

// ==== bench/dcache_tb.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_tb;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 16;

    localparam dcache_pkg::core_wr_t CW_IDLE =
        {1'b1, {($bits(dcache_pkg::core_wr_t)-1){1'b0}}};
    localparam dcache_pkg::core_rd_t CR_IDLE =
        {1'b1, {($bits(dcache_pkg::core_rd_t)-1){1'b0}}};
    localparam dcache_pkg::line_req_t LINE_IDLE =
        {1'b1, {($bits(dcache_pkg::line_req_t)-1){1'b0}}};

    // one row per cycle, with the busy flags it should raise
    typedef struct packed {
        dcache_pkg::core_wr_t cw;
        dcache_pkg::core_rd_t cr;
        dcache_pkg::line_req_t lw;
        dcache_pkg::line_req_t lr;
        logic exp_wbusy;
        logic exp_rbusy;
        logic [`BANK_W-1:0] exp_rbank;
    } step_t;

    typedef struct packed {
        logic [`CASSOC-1:0][31:0] core;
        logic [`CWIDTH-1:0][31:0] line;
    } rd_exp_t;

    logic clk;
    logic rst_n;
    dcache_pkg::core_wr_t core_wr;
    dcache_pkg::core_rd_t core_rd;
    dcache_pkg::line_req_t line_wr;
    dcache_pkg::line_req_t line_rd;
    logic [`CASSOC-1:0][31:0] core_rdata;
    logic [`CWIDTH-1:0][31:0] line_rdata;
    logic wbusy;
    logic rbusy;
    logic [`BANK_W-1:0] rbusy_bank;

    step_t steps[$];
    logic [31:0] rand_words [64];
    logic [31:0] ref_mem [`CASSOC][1 << `IDX_W];
    // two-entry delay line of expected read data
    rd_exp_t exp_pipe [2];
    int seed;
    int errors;
    bit table_ready = 1'b0;

    dcache_banks dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .core_wr    (core_wr),
        .core_rd    (core_rd),
        .line_wr    (line_wr),
        .line_rd    (line_rd),
        .core_rdata (core_rdata),
        .line_rdata (line_rdata),
        .wbusy      (wbusy),
        .rbusy      (rbusy),
        .rbusy_bank (rbusy_bank)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    initial begin
        wait (table_ready);
        #((steps.size() + 64) * CLK_PERIOD);
        $display("watchdog expired before the stimulus table finished");
        $display("Some tests failed");
        $fatal(1, "simulation timed out");
    end

    // core index is row, bank, word from the top
    function automatic logic [`IDX_W-1:0] word_idx(int row, int bank, int word);
        return {row[`ROW_W-1:0], bank[`BANK_W-1:0], word[`WORD_W-1:0]};
    endfunction

    // line address is way, row, bank from the top
    function automatic logic [`LINE_W-1:0] line_addr(int way, int row, int bank);
        return {way[`WAY_W-1:0], row[`ROW_W-1:0], bank[`BANK_W-1:0]};
    endfunction

    function automatic logic [`BANK_W-1:0] idx_bank(logic [`IDX_W-1:0] idx);
        return idx[`WORD_W +: `BANK_W];
    endfunction

    function automatic logic [`BANK_W-1:0] line_bank(logic [`LINE_W-1:0] line);
        return line[`BANK_W-1:0];
    endfunction

    function automatic logic [`WAY_W-1:0] line_way(logic [`LINE_W-1:0] line);
        return line[`BANK_W+`ROW_W +: `WAY_W];
    endfunction

    function automatic logic [`IDX_W-1:0] line_word(logic [`LINE_W-1:0] line, int w);
        return {line[`BANK_W +: `ROW_W], line[`BANK_W-1:0], w[`WORD_W-1:0]};
    endfunction

    function automatic dcache_pkg::core_wr_t core_store(int way, logic [`IDX_W-1:0] idx,
            logic [31:0] data, logic [3:0] mask);
        dcache_pkg::core_wr_t r;
        r.ce_n = 1'b0;
        r.way = way[`WAY_W-1:0];
        r.idx = idx;
        r.data = data;
        r.wmask = mask;
        return r;
    endfunction

    function automatic dcache_pkg::core_rd_t core_load(logic [`IDX_W-1:0] idx);
        dcache_pkg::core_rd_t r;
        r.ce_n = 1'b0;
        r.idx = idx;
        return r;
    endfunction

    function automatic dcache_pkg::line_req_t refill(int way, int row, int bank, int first);
        dcache_pkg::line_req_t r;
        r.ce_n = 1'b0;
        r.line = line_addr(way, row, bank);
        for (int w = 0; w < `CWIDTH; w++)
            r.data[w] = rand_words[first + w];
        r.wmask = '1;
        return r;
    endfunction

    function automatic dcache_pkg::line_req_t writeback(int way, int row, int bank);
        dcache_pkg::line_req_t r;
        r = LINE_IDLE;
        r.ce_n = 1'b0;
        r.line = line_addr(way, row, bank);
        return r;
    endfunction

    task automatic add_step(input dcache_pkg::core_wr_t cw, input dcache_pkg::core_rd_t cr,
            input dcache_pkg::line_req_t lw, input dcache_pkg::line_req_t lr,
            input logic wb, input logic rb, input int rbank);
        step_t s;
        s.cw = cw;
        s.cr = cr;
        s.lw = lw;
        s.lr = lr;
        s.exp_wbusy = wb;
        s.exp_rbusy = rb;
        s.exp_rbank = rbank[`BANK_W-1:0];
        steps.push_back(s);
    endtask

    task automatic build_table();
        logic [31:0] pick;
        // quiet cycles right after reset
        repeat (2) add_step(CW_IDLE, CR_IDLE, LINE_IDLE, LINE_IDLE, 0, 0, 0);
        for (int way = 0; way < `CASSOC; way++)
            for (int bank = 0; bank < `CBANKS; bank++)
                add_step(CW_IDLE, CR_IDLE, refill(way, 5, bank, (way*`CBANKS + bank)*2),
                    LINE_IDLE, 0, 0, 0);
        // partial store into way 1
        add_step(core_store(1, word_idx(5, 2, 1), 32'ha5a5_5a5a, 4'b0101), CR_IDLE,
            LINE_IDLE, LINE_IDLE, 0, 0, 0);
        add_step(CW_IDLE, core_load(word_idx(5, 2, 1)), LINE_IDLE, LINE_IDLE, 0, 0, 0);
        // refill then load and write back
        add_step(CW_IDLE, CR_IDLE, refill(0, 12, 3, 16), LINE_IDLE, 0, 0, 0);
        add_step(CW_IDLE, CR_IDLE, refill(1, 12, 3, 18), LINE_IDLE, 0, 0, 0);
        add_step(CW_IDLE, core_load(word_idx(12, 3, 0)), LINE_IDLE, LINE_IDLE, 0, 0, 0);
        add_step(CW_IDLE, core_load(word_idx(12, 3, 1)), LINE_IDLE, LINE_IDLE, 0, 0, 0);
        add_step(CW_IDLE, CR_IDLE, LINE_IDLE, writeback(0, 12, 3), 0, 1, 3);
        // same bank, refill wins
        add_step(core_store(0, word_idx(5, 1, 0), 32'hdead_beef, 4'hf), CR_IDLE,
            refill(1, 5, 1, 20), LINE_IDLE, 1, 0, 0);
        add_step(CW_IDLE, core_load(word_idx(5, 1, 0)), LINE_IDLE, LINE_IDLE, 0, 0, 0);
        add_step(CW_IDLE, core_load(word_idx(5, 1, 1)), LINE_IDLE, LINE_IDLE, 0, 0, 0);
        // different banks, both land
        add_step(core_store(0, word_idx(5, 0, 1), 32'h1234_5678, 4'hf), CR_IDLE,
            refill(1, 5, 3, 22), LINE_IDLE, 0, 0, 0);
        add_step(CW_IDLE, core_load(word_idx(5, 0, 1)), LINE_IDLE, writeback(1, 5, 3), 0, 1, 3);
        add_step(CW_IDLE, core_load(word_idx(5, 1, 1)), LINE_IDLE, writeback(1, 5, 2), 0, 1, 2);
        // core load loses its bank to write-back
        add_step(CW_IDLE, core_load(word_idx(5, 2, 0)), LINE_IDLE, writeback(0, 5, 2), 0, 1, 2);
        for (int i = 0; i < 8; i++)
            add_step(CW_IDLE, core_load(word_idx(5, i % `CBANKS, i / `CBANKS)),
                LINE_IDLE, LINE_IDLE, 0, 0, 0);
        for (int i = 0; i < 16; i++) begin
            pick = $random(seed);
            add_step(CW_IDLE, core_load(word_idx(5, int'(pick[2:1]), int'(pick[0]))),
                LINE_IDLE, LINE_IDLE, 0, 0, 0);
        end
        // drain the read pipeline
        repeat (3) add_step(CW_IDLE, CR_IDLE, LINE_IDLE, LINE_IDLE, 0, 0, 0);
    endtask

    function automatic rd_exp_t expected_reads(step_t s);
        rd_exp_t e;
        e = '0;
        if (!s.cr.ce_n && !(!s.lr.ce_n && line_bank(s.lr.line) == idx_bank(s.cr.idx)))
            for (int a = 0; a < `CASSOC; a++)
                e.core[a] = ref_mem[a][s.cr.idx];
        if (!s.lr.ce_n)
            for (int w = 0; w < `CWIDTH; w++)
                e.line[w] = ref_mem[line_way(s.lr.line)][line_word(s.lr.line, w)];
        return e;
    endfunction

    task automatic apply_writes(input step_t s);
        logic [`IDX_W-1:0] idx;
        if (!s.cw.ce_n && !(!s.lw.ce_n && line_bank(s.lw.line) == idx_bank(s.cw.idx))) begin
            for (int j = 0; j < 4; j++)
                if (s.cw.wmask[j])
                    ref_mem[s.cw.way][s.cw.idx][8*j +: 8] = s.cw.data[8*j +: 8];
        end
        if (!s.lw.ce_n) begin
            for (int w = 0; w < `CWIDTH; w++) begin
                idx = line_word(s.lw.line, w);
                for (int j = 0; j < 4; j++)
                    if (s.lw.wmask[w][j])
                        ref_mem[line_way(s.lw.line)][idx][8*j +: 8] = s.lw.data[w][8*j +: 8];
            end
        end
    endtask

    task automatic report_fail(input string name, input logic [63:0] exp,
            input logic [63:0] got);
        errors++;
        $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, got);
        $display("Some tests failed");
        $fatal(1, "stopping at first mismatch");
    endtask

    // entered on a falling edge, leaves on the next one
    task automatic run_step(input step_t s);
        assert (core_rdata === exp_pipe[1].core)
            else report_fail("core_rdata", 64'(exp_pipe[1].core), 64'(core_rdata));
        assert (line_rdata === exp_pipe[1].line)
            else report_fail("line_rdata", 64'(exp_pipe[1].line), 64'(line_rdata));
        exp_pipe[1] = exp_pipe[0];
        core_wr = s.cw;
        core_rd = s.cr;
        line_wr = s.lw;
        line_rd = s.lr;
        #1;
        assert (wbusy === s.exp_wbusy)
            else report_fail("wbusy", 64'(s.exp_wbusy), 64'(wbusy));
        assert (rbusy === s.exp_rbusy)
            else report_fail("rbusy", 64'(s.exp_rbusy), 64'(rbusy));
        assert (rbusy_bank === s.exp_rbank)
            else report_fail("rbusy_bank", 64'(s.exp_rbank), 64'(rbusy_bank));
        exp_pipe[0] = expected_reads(s);
        apply_writes(s);
        @(negedge clk);
    endtask

    initial begin
        seed = 72230;
        errors = 0;
        rst_n = 1'b0;
        core_wr = CW_IDLE;
        core_rd = CR_IDLE;
        line_wr = LINE_IDLE;
        line_rd = LINE_IDLE;
        exp_pipe[0] = '0;
        exp_pipe[1] = '0;
        for (int i = 0; i < 64; i++)
            rand_words[i] = $random(seed);
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (steps[i])
            run_step(steps[i]);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+common
common/dcache_pkg.sv
dcache/dcache_sram.sv
dcache/dcache_wr_route.sv
dcache/dcache_rd_route.sv
dcache/dcache_banks.sv
bench/dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the dcache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -f build.f --top-module dcache_tb -o dcache_tb_sim \
    && ./obj_dir/dcache_tb_sim 2>&1 | tee sim.log

grep -q "All tests passed" sim.log && echo PASS || { echo FAIL; exit 1; }
